/* rtl/tile_net_pkg.sv */
/*
 * Tile network definitions
 * Request payload, router link format, flit constants and the
 * configuration register map shared by the tile request network.
 */

package tile_net_pkg;

   // Coherence request as handed over by the local agent
   typedef struct packed
   {
      logic [2:0]  dst_id;
      logic [2:0]  src_id;
      logic [1:0]  msg_type;
      logic [31:0] addr;
   } lce_req_s;

   localparam int REQ_WIDTH = $bits(lce_req_s);

   // One flit on a router link
   localparam int FLIT_WIDTH = 16;

   // Header len field, flits that follow the header
   localparam int LEN_WIDTH = 2;

   // One direction of a ready-and link
   typedef struct packed
   {
      logic                  v;
      logic [FLIT_WIDTH-1:0] data;
      logic                  ready_and_rev;
   } wh_link_s;

   // Router port indices
   localparam logic [1:0] P = 2'd0;
   localparam logic [1:0] W = 2'd1;
   localparam logic [1:0] E = 2'd2;

   // Configuration write channel
   localparam int CFG_ADDR_WIDTH = 8;
   localparam int CFG_DATA_WIDTH = 32;

   // Bit 0 of the write data is the new freeze value
   localparam logic [CFG_ADDR_WIDTH-1:0] CFG_ADDR_FREEZE = 8'h00;

   /*
    * Packet layout, low bits first:
    *   destination column, x_cord_width_p bits
    *   len, LEN_WIDTH bits
    *   request payload, REQ_WIDTH bits
    *   zero padding up to a whole flit
    */

endpackage

/* rtl/tile_ctrl.sv */
/*
 * Tile control
 * Delays the network reset by one cycle and holds the freeze bit,
 * which reset sets and a configuration write clears.
 */
`timescale 1ns/1ps

module tile_ctrl
   (input                                         clk_i
    , input                                       reset_i
    , input                                       cfg_w_v_i
    , input  [tile_net_pkg::CFG_ADDR_WIDTH-1:0]   cfg_addr_i
    , input  [tile_net_pkg::CFG_DATA_WIDTH-1:0]   cfg_data_i
    , output logic                                net_reset_o
    , output logic                                freeze_o
    );

   import tile_net_pkg::*;

   logic freeze_wr;

   assign freeze_wr = cfg_w_v_i & (cfg_addr_i == CFG_ADDR_FREEZE);

   // Registered copy of reset for the network
   always_ff @(posedge clk_i)
   begin
      net_reset_o <= reset_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         freeze_o <= 1'b1;
      end
      else if (freeze_wr)
      begin
         freeze_o <= cfg_data_i[0];
      end
   end

endmodule

/* rtl/wh_inject.sv */
/*
 * Request injection adapter
 * Wraps one request payload into a wormhole packet and sends it to
 * the router local port one flit per transfer. No request is taken
 * while the tile is frozen.
 */
`timescale 1ns/1ps

module wh_inject
   #(parameter x_cord_width_p = 4)
   (input                              clk_i
    , input                            reset_i
    , input                            freeze_i
    , input  tile_net_pkg::lce_req_s   req_i
    , input                            req_v_i
    , output logic                     req_ready_o
    , input  tile_net_pkg::wh_link_s   link_i
    , output tile_net_pkg::wh_link_s   link_o
    );

   import tile_net_pkg::*;

   localparam int pkt_width_lp = x_cord_width_p + LEN_WIDTH + REQ_WIDTH;
   localparam int num_flits_lp = (pkt_width_lp + FLIT_WIDTH - 1) / FLIT_WIDTH;
   localparam int pkt_pad_lp   = num_flits_lp * FLIT_WIDTH;
   localparam int cnt_width_lp = (num_flits_lp > 1) ? $clog2(num_flits_lp) : 1;

   typedef enum logic [1:0] {ST_INIT, ST_IDLE, ST_SEND} state_e;

   state_e                    state_r;
   logic [cnt_width_lp-1:0]   cnt_r;
   logic [pkt_pad_lp-1:0]     pkt_r;
   logic [x_cord_width_p-1:0] dst_x;
   logic [LEN_WIDTH-1:0]      len;
   logic                      accept;
   logic                      flit_taken;
   logic                      last_flit;

   // Directors sit on even columns
   assign dst_x = x_cord_width_p'({req_i.dst_id, 1'b0});
   assign len   = LEN_WIDTH'(num_flits_lp - 1);

   assign req_ready_o = (state_r == ST_IDLE) & ~freeze_i;
   assign accept      = req_v_i & req_ready_o;
   assign flit_taken  = (state_r == ST_SEND) & link_i.ready_and_rev;
   assign last_flit   = (cnt_r == cnt_width_lp'(num_flits_lp - 1));

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r <= ST_INIT;
         cnt_r   <= '0;
      end
      else
      begin
         case (state_r)
            ST_INIT:
               state_r <= ST_IDLE;
            ST_IDLE:
               if (accept)
               begin
                  state_r <= ST_SEND;
                  cnt_r   <= '0;
               end
            ST_SEND:
               if (flit_taken)
               begin
                  cnt_r <= cnt_r + 1'b1;
                  if (last_flit)
                  begin
                     state_r <= ST_IDLE;
                  end
               end
            default:
               state_r <= ST_INIT;
         endcase
      end
   end

   // Header flit goes first, then shift down one flit per transfer
   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         pkt_r <= pkt_pad_lp'({req_i, len, dst_x});
      end
      else if (flit_taken)
      begin
         pkt_r <= pkt_r >> FLIT_WIDTH;
      end
   end

   assign link_o.v             = (state_r == ST_SEND);
   assign link_o.data          = pkt_r[FLIT_WIDTH-1:0];
   assign link_o.ready_and_rev = 1'b0;

endmodule

/* rtl/wh_router.sv */
/*
 * Three port wormhole router, one dimension
 * Ports P, W and E each have a two flit input buffer. Headers are
 * routed by destination column against my_x_i, and each output is
 * held by one input until the packet tail has passed. Outputs are
 * registered and arbitrated round robin.
 */
`timescale 1ns/1ps

module wh_router
   #(parameter x_cord_width_p = 4)
   (input                                                          clk_i
    , input                                                        reset_i
    , input  [x_cord_width_p-1:0]                                  my_x_i
    , input  tile_net_pkg::wh_link_s [tile_net_pkg::E:tile_net_pkg::P] link_i
    , output tile_net_pkg::wh_link_s [tile_net_pkg::E:tile_net_pkg::P] link_o
    );

   import tile_net_pkg::*;

   localparam int dirs_lp = 3;

   logic [FLIT_WIDTH-1:0] fifo_mem [dirs_lp][2];

   logic [dirs_lp-1:0]                 wr_ptr_r;
   logic [dirs_lp-1:0]                 rd_ptr_r;
   logic [dirs_lp-1:0][1:0]            cnt_r;
   logic [dirs_lp-1:0]                 head_v;
   logic [dirs_lp-1:0][FLIT_WIDTH-1:0] head;
   logic [dirs_lp-1:0][1:0]            req_dir;
   logic [dirs_lp-1:0]                 push;
   logic [dirs_lp-1:0]                 pop;

   logic [dirs_lp-1:0]                 out_busy_r;
   logic [dirs_lp-1:0][1:0]            owner_r;
   logic [dirs_lp-1:0][LEN_WIDTH-1:0]  rem_r;
   logic [dirs_lp-1:0][1:0]            rr_r;
   logic [dirs_lp-1:0]                 out_v_r;
   logic [dirs_lp-1:0][FLIT_WIDTH-1:0] out_data_r;
   logic [dirs_lp-1:0][1:0]            sel;
   logic [dirs_lp-1:0]                 fire;

   function automatic logic [1:0] route_dir
      (input logic [x_cord_width_p-1:0] dst_x
       , input logic [x_cord_width_p-1:0] here_x);
      logic [1:0] dir;
      if (dst_x < here_x)
         dir = W;
      else if (dst_x > here_x)
         dir = E;
      else
         dir = P;
      return dir;
   endfunction

   // Body flits follow the output their input already holds
   always_comb
   begin
      for (int i = 0; i < dirs_lp; i++)
      begin
         head_v[i]  = (cnt_r[i] != 2'd0);
         head[i]    = fifo_mem[i][rd_ptr_r[i]];
         push[i]    = link_i[i].v & (cnt_r[i] != 2'd2);
         req_dir[i] = route_dir(head[i][x_cord_width_p-1:0], my_x_i);
         for (int o = 0; o < dirs_lp; o++)
         begin
            if (out_busy_r[o] && (owner_r[o] == 2'(i)))
               req_dir[i] = 2'(o);
         end
      end
   end

   always_comb
   begin
      logic found;
      int   idx;
      pop = '0;
      for (int o = 0; o < dirs_lp; o++)
      begin
         sel[o] = owner_r[o];
         found  = out_busy_r[o];
         // Free output, search from the input after the last winner
         for (int k = 1; k <= dirs_lp; k++)
         begin
            idx = (int'(rr_r[o]) + k) % dirs_lp;
            if (!found && head_v[idx] && (req_dir[idx] == 2'(o)))
            begin
               found  = 1'b1;
               sel[o] = 2'(idx);
            end
         end
         fire[o] = found & head_v[sel[o]] & (~out_v_r[o] | link_i[o].ready_and_rev);
         if (fire[o])
            pop[sel[o]] = 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      for (int i = 0; i < dirs_lp; i++)
      begin
         if (push[i])
            fifo_mem[i][wr_ptr_r[i]] <= link_i[i].data;
      end
      for (int o = 0; o < dirs_lp; o++)
      begin
         if (fire[o])
            out_data_r[o] <= head[sel[o]];
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wr_ptr_r   <= '0;
         rd_ptr_r   <= '0;
         cnt_r      <= '0;
         out_busy_r <= '0;
         owner_r    <= '0;
         rem_r      <= '0;
         rr_r       <= '0;
         out_v_r    <= '0;
      end
      else
      begin
         for (int i = 0; i < dirs_lp; i++)
         begin
            wr_ptr_r[i] <= wr_ptr_r[i] ^ push[i];
            rd_ptr_r[i] <= rd_ptr_r[i] ^ pop[i];
            cnt_r[i]    <= cnt_r[i] + {1'b0, push[i]} - {1'b0, pop[i]};
         end
         for (int o = 0; o < dirs_lp; o++)
         begin
            if (fire[o])
               out_v_r[o] <= 1'b1;
            else if (link_i[o].ready_and_rev)
               out_v_r[o] <= 1'b0;

            if (fire[o] && out_busy_r[o])
            begin
               rem_r[o] <= rem_r[o] - 1'b1;
               if (rem_r[o] == LEN_WIDTH'(1))
                  out_busy_r[o] <= 1'b0;
            end
            else if (fire[o])
            begin
               // Header wins, lock the output for len more flits
               rr_r[o]       <= sel[o];
               owner_r[o]    <= sel[o];
               rem_r[o]      <= head[sel[o]][x_cord_width_p +: LEN_WIDTH];
               out_busy_r[o] <= (head[sel[o]][x_cord_width_p +: LEN_WIDTH] != '0);
            end
         end
      end
   end

   always_comb
   begin
      for (int d = 0; d < dirs_lp; d++)
      begin
         link_o[d].v             = out_v_r[d];
         link_o[d].data          = out_data_r[d];
         link_o[d].ready_and_rev = (cnt_r[d] != 2'd2);
      end
   end

endmodule

/* rtl/wh_eject.sv */
/*
 * Request ejection adapter
 * Collects the flits of one packet from the router local port and
 * presents the rebuilt request payload to the local agent.
 */
`timescale 1ns/1ps

module wh_eject
   #(parameter x_cord_width_p = 4)
   (input                              clk_i
    , input                            reset_i
    , input  tile_net_pkg::wh_link_s   link_i
    , output tile_net_pkg::wh_link_s   link_o
    , output tile_net_pkg::lce_req_s   req_o
    , output logic                     req_v_o
    , input                            req_ready_i
    );

   import tile_net_pkg::*;

   localparam int pkt_width_lp = x_cord_width_p + LEN_WIDTH + REQ_WIDTH;
   localparam int num_flits_lp = (pkt_width_lp + FLIT_WIDTH - 1) / FLIT_WIDTH;
   localparam int pkt_pad_lp   = num_flits_lp * FLIT_WIDTH;
   localparam int cnt_width_lp = (num_flits_lp > 1) ? $clog2(num_flits_lp) : 1;

   logic                    hold_r;
   logic [cnt_width_lp-1:0] cnt_r;
   logic [LEN_WIDTH-1:0]    len_r;
   logic [LEN_WIDTH-1:0]    len_cur;
   logic [pkt_pad_lp-1:0]   pkt_r;
   logic                    flit_in;
   logic                    last_in;

   assign flit_in = link_i.v & ~hold_r;

   // Header carries len, later flits use the saved copy
   assign len_cur = (cnt_r == '0) ? link_i.data[x_cord_width_p +: LEN_WIDTH] : len_r;
   assign last_in = (cnt_r == cnt_width_lp'(len_cur));

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         hold_r <= 1'b0;
         cnt_r  <= '0;
         len_r  <= '0;
      end
      else if (flit_in)
      begin
         len_r  <= len_cur;
         cnt_r  <= last_in ? '0 : cnt_r + 1'b1;
         hold_r <= last_in;
      end
      else if (hold_r & req_ready_i)
      begin
         hold_r <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (flit_in)
         pkt_r[cnt_r*FLIT_WIDTH +: FLIT_WIDTH] <= link_i.data;
   end

   assign req_v_o = hold_r;
   assign req_o   = lce_req_s'(pkt_r[x_cord_width_p+LEN_WIDTH +: REQ_WIDTH]);

   // Receive only, nothing goes back into the router
   assign link_o.v             = 1'b0;
   assign link_o.data          = '0;
   assign link_o.ready_and_rev = ~hold_r;

endmodule

/* rtl/tile_net_top.sv */
/*
 * Tile request network
 * Local request injection and ejection around a three port wormhole
 * router, with the tile freeze and delayed network reset.
 */
`timescale 1ns/1ps

module tile_net_top
   #(parameter x_cord_width_p = 4)
   (input                                                          clk_i
    , input                                                        reset_i
    , input  [x_cord_width_p-1:0]                                  my_x_i

    , input                                                        cfg_w_v_i
    , input  [tile_net_pkg::CFG_ADDR_WIDTH-1:0]                    cfg_addr_i
    , input  [tile_net_pkg::CFG_DATA_WIDTH-1:0]                    cfg_data_i

    , input  tile_net_pkg::lce_req_s                               req_i
    , input                                                        req_v_i
    , output logic                                                 req_ready_o

    , output tile_net_pkg::lce_req_s                               req_o
    , output logic                                                 req_v_o
    , input                                                        req_ready_i

    , input  tile_net_pkg::wh_link_s [tile_net_pkg::E:tile_net_pkg::W] link_i
    , output tile_net_pkg::wh_link_s [tile_net_pkg::E:tile_net_pkg::W] link_o
    );

   import tile_net_pkg::*;

   logic net_reset;
   logic freeze;

   wh_link_s [E:P] rtr_link_li;
   wh_link_s [E:P] rtr_link_lo;
   wh_link_s       inj_link_li;
   wh_link_s       inj_link_lo;
   wh_link_s       ej_link_li;
   wh_link_s       ej_link_lo;

   tile_ctrl ctrl
      (.clk_i        (clk_i)
       , .reset_i    (reset_i)
       , .cfg_w_v_i  (cfg_w_v_i)
       , .cfg_addr_i (cfg_addr_i)
       , .cfg_data_i (cfg_data_i)
       , .net_reset_o(net_reset)
       , .freeze_o   (freeze)
       );

   wh_inject #(.x_cord_width_p(x_cord_width_p)) inject
      (.clk_i        (clk_i)
       , .reset_i    (net_reset)
       , .freeze_i   (freeze)
       , .req_i      (req_i)
       , .req_v_i    (req_v_i)
       , .req_ready_o(req_ready_o)
       , .link_i     (inj_link_li)
       , .link_o     (inj_link_lo)
       );

   // Local port pairs the injection flits with the ejection ready
   assign rtr_link_li[P] = '{v: inj_link_lo.v, data: inj_link_lo.data,
                             ready_and_rev: ej_link_lo.ready_and_rev};
   assign inj_link_li    = '{v: 1'b0, data: '0,
                             ready_and_rev: rtr_link_lo[P].ready_and_rev};
   assign ej_link_li     = '{v: rtr_link_lo[P].v, data: rtr_link_lo[P].data,
                             ready_and_rev: 1'b0};

   assign rtr_link_li[E:W] = link_i;
   assign link_o           = rtr_link_lo[E:W];

   wh_router #(.x_cord_width_p(x_cord_width_p)) router
      (.clk_i     (clk_i)
       , .reset_i (net_reset)
       , .my_x_i  (my_x_i)
       , .link_i  (rtr_link_li)
       , .link_o  (rtr_link_lo)
       );

   wh_eject #(.x_cord_width_p(x_cord_width_p)) eject
      (.clk_i        (clk_i)
       , .reset_i    (net_reset)
       , .link_i     (ej_link_li)
       , .link_o     (ej_link_lo)
       , .req_o      (req_o)
       , .req_v_o    (req_v_o)
       , .req_ready_i(req_ready_i)
       );

endmodule

/* sim/tile_net_checker.sv */
/*
 * Tile network protocol checker
 * Handshake stability on the request ports, the local injection link
 * and both neighbor links, plus freeze gating of injection.
 */
`timescale 1ns/1ps

module tile_net_checker
   (input                                           clk_i
    , input                                         reset_i
    , input                                         net_reset_i
    , input                                         freeze_i
    , input  tile_net_pkg::lce_req_s                req_in_i
    , input                                         req_in_v_i
    , input                                         req_in_ready_i
    , input  tile_net_pkg::lce_req_s                req_out_i
    , input                                         req_out_v_i
    , input                                         req_out_ready_i
    , input  tile_net_pkg::wh_link_s                inj_link_i
    , input                                         inj_ready_i
    , input  tile_net_pkg::wh_link_s [tile_net_pkg::E:tile_net_pkg::W] link_out_i
    , input  tile_net_pkg::wh_link_s [tile_net_pkg::E:tile_net_pkg::W] link_in_i
    );

   import tile_net_pkg::*;

   int   fail_count = 0;
   logic active;

   // Network reset trails the tile reset by a cycle
   assign active = ~reset_i & ~net_reset_i;

   req_in_hold: assert property (@(posedge clk_i) disable iff (!active)
      req_in_v_i && !req_in_ready_i |=> req_in_v_i && $stable(req_in_i))
      else begin $error("req_i dropped or changed before acceptance"); fail_count++; end

   req_out_hold: assert property (@(posedge clk_i) disable iff (!active)
      req_out_v_i && !req_out_ready_i |=> req_out_v_i && $stable(req_out_i))
      else begin $error("req_o dropped or changed before acceptance"); fail_count++; end

   inj_hold: assert property (@(posedge clk_i) disable iff (!active)
      inj_link_i.v && !inj_ready_i |=> inj_link_i.v && $stable(inj_link_i.data))
      else begin $error("Local flit dropped or changed before acceptance"); fail_count++; end

   west_hold: assert property (@(posedge clk_i) disable iff (!active)
      link_out_i[W].v && !link_in_i[W].ready_and_rev
      |=> link_out_i[W].v && $stable(link_out_i[W].data))
      else begin $error("West flit dropped or changed before acceptance"); fail_count++; end

   east_hold: assert property (@(posedge clk_i) disable iff (!active)
      link_out_i[E].v && !link_in_i[E].ready_and_rev
      |=> link_out_i[E].v && $stable(link_out_i[E].data))
      else begin $error("East flit dropped or changed before acceptance"); fail_count++; end

   // Nothing leaves the local port while frozen
   freeze_gate: assert property (@(posedge clk_i) disable iff (!active)
      freeze_i |-> !inj_link_i.v)
      else begin $error("Injection active while frozen"); fail_count++; end

endmodule

bind tile_net_top tile_net_checker chk
   (.clk_i            (clk_i)
    , .reset_i        (reset_i)
    , .net_reset_i    (net_reset)
    , .freeze_i       (freeze)
    , .req_in_i       (req_i)
    , .req_in_v_i     (req_v_i)
    , .req_in_ready_i (req_ready_o)
    , .req_out_i      (req_o)
    , .req_out_v_i    (req_v_o)
    , .req_out_ready_i(req_ready_i)
    , .inj_link_i     (inj_link_lo)
    , .inj_ready_i    (inj_link_li.ready_and_rev)
    , .link_out_i     (link_o)
    , .link_in_i      (link_i)
    );

/* sim/tile_net_tb.sv */
/*
 * Tile request network testbench
 * Local agent and both neighbors send random packets under random
 * back-pressure; a scoreboard matches every arrival per source.
 */
`timescale 1ns/1ps

module tile_net_tb;

   import tile_net_pkg::*;

   localparam int         X_W         = 4;
   localparam int         NUM_FLITS   = 3;
   localparam int         NUM_PKTS    = 24;
   localparam int         DRAIN_LIMIT = 20000;
   localparam logic [3:0] MY_X        = 4'd6;

   logic                      clk_i       = 1'b0;
   logic                      reset_i     = 1'b1;
   logic [X_W-1:0]            my_x_i      = MY_X;
   logic                      cfg_w_v_i   = 1'b0;
   logic [CFG_ADDR_WIDTH-1:0] cfg_addr_i  = '0;
   logic [CFG_DATA_WIDTH-1:0] cfg_data_i  = '0;
   lce_req_s                  req_i       = '0;
   logic                      req_v_i     = 1'b0;
   logic                      req_ready_o;
   lce_req_s                  req_o;
   logic                      req_v_o;
   logic                      req_ready_i = 1'b0;
   wh_link_s [E:W]            link_i      = '0;
   wh_link_s [E:W]            link_o;

   logic [15:0] lfsr_q     = 16'd24360;
   logic        freeze_chk = 1'b0;
   logic        run        = 1'b0;
   lce_req_s    src_q [3][$];
   logic [47:0] exp_q [3][3][$];
   logic [47:0] rx_pkt [3];
   int          rx_idx [3];
   int          tx_idx [3];

   tile_net_top #(.x_cord_width_p(X_W)) DUT
      (.clk_i(clk_i), .reset_i(reset_i), .my_x_i(my_x_i)
       , .cfg_w_v_i(cfg_w_v_i), .cfg_addr_i(cfg_addr_i), .cfg_data_i(cfg_data_i)
       , .req_i(req_i), .req_v_i(req_v_i), .req_ready_o(req_ready_o)
       , .req_o(req_o), .req_v_o(req_v_o), .req_ready_i(req_ready_i)
       , .link_i(link_i), .link_o(link_o));

   always #20 clk_i = ~clk_i;

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
         r[i] = lfsr_q[0];
      end
      return r;
   endfunction

   // Exit port from the director column against this tile
   function automatic logic [1:0] route_ref(input logic [2:0] dst_id);
      logic [3:0] col;
      col = {dst_id, 1'b0};
      if (col < MY_X)
         return W;
      else if (col > MY_X)
         return E;
      return P;
   endfunction

   // Column, len, payload, then zero pad; header is the low flit
   function automatic logic [47:0] pack_ref(input lce_req_s req);
      logic [47:0] pkt;
      pkt       = '0;
      pkt[3:0]  = {req.dst_id, 1'b0};
      pkt[5:4]  = 2'(NUM_FLITS - 1);
      pkt[45:6] = req;
      return pkt;
   endfunction

   function automatic bit drained();
      for (int a = 0; a < 3; a++)
      begin
         if (src_q[a].size() != 0)
            return 1'b0;
         for (int b = 0; b < 3; b++)
            if (exp_q[a][b].size() != 0)
               return 1'b0;
      end
      return 1'b1;
   endfunction

   task automatic abort_run();
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic compare(input string name, input logic [63:0] exp_v,
                          input logic [63:0] act_v);
      if (act_v !== exp_v)
      begin
         $display("Fail %s: expected %h, actual %h", name, exp_v, act_v);
         abort_run();
      end
   endtask

   // src_id tags the source, so order is checked per source and exit
   task automatic check_arrival(input int exit_dir, input logic [47:0] pkt, input string name);
      lce_req_s    got;
      logic [47:0] exp_pkt;
      got = pkt[45:6];
      if (got.src_id > 3'd2 || exp_q[exit_dir][got.src_id].size() == 0)
      begin
         $display("Unexpected arrival at %s from source %0d", name, got.src_id);
         abort_run();
      end
      else
      begin
         exp_pkt = exp_q[exit_dir][got.src_id].pop_front();
         if (exit_dir == P)
            compare(name, exp_pkt[45:6], pkt[45:6]);
         else
            compare(name, exp_pkt, pkt);
      end
   endtask

   // Inputs change just after the edge, from state sampled at the edge
   always @(posedge clk_i)
   begin : drive
      logic        en_q;
      logic        run_q;
      logic [31:0] r;
      logic [47:0] pkt;
      en_q  = ~reset_i;
      run_q = run;
      #1;
      r = rand_bits(6);
      req_ready_i             = |r[1:0];
      link_i[W].ready_and_rev = |r[3:2];
      link_i[E].ready_and_rev = |r[5:4];
      req_v_i = en_q && (src_q[P].size() != 0);
      if (req_v_i)
         req_i = src_q[P][0];
      for (int d = W; d <= E; d++)
      begin
         link_i[d].v = run_q && (src_q[d].size() != 0);
         if (link_i[d].v)
         begin
            pkt = pack_ref(src_q[d][0]);
            link_i[d].data = pkt[tx_idx[d]*16 +: 16];
         end
      end
   end

   // Handshakes and outputs sampled mid-cycle
   always @(negedge clk_i)
   begin : monitor
      logic [47:0] pkt;
      if (!reset_i)
      begin
         if (DUT.chk.fail_count != 0)
         begin
            $display("Protocol checker reported an assertion failure");
            abort_run();
         end
         if (freeze_chk)
         begin
            compare("freeze req_ready_o", 0, req_ready_o);
            compare("freeze req_v_o", 0, req_v_o);
            compare("freeze link_o[W].v", 0, link_o[W].v);
            compare("freeze link_o[E].v", 0, link_o[E].v);
         end
         if (req_v_i && req_ready_o)
            void'(src_q[P].pop_front());
         for (int d = W; d <= E; d++)
         begin
            if (link_i[d].v && link_o[d].ready_and_rev)
            begin
               tx_idx[d]++;
               if (tx_idx[d] == NUM_FLITS)
               begin
                  tx_idx[d] = 0;
                  void'(src_q[d].pop_front());
               end
            end
            if (link_o[d].v && link_i[d].ready_and_rev)
            begin
               rx_pkt[d][rx_idx[d]*16 +: 16] = link_o[d].data;
               rx_idx[d]++;
               if (rx_idx[d] == NUM_FLITS)
               begin
                  rx_idx[d] = 0;
                  check_arrival(d, rx_pkt[d], (d == W) ? "link_o[W] packet" : "link_o[E] packet");
               end
            end
         end
         if (req_v_o && req_ready_i)
         begin
            pkt       = '0;
            pkt[45:6] = req_o;
            check_arrival(P, pkt, "req_o payload");
         end
      end
   end

   initial
   begin : main
      lce_req_s    req;
      logic [31:0] r;
      int          t;
      // West sends to columns 6 and up, east to 6 and below
      // The first local request stays on this tile
      for (int s = 0; s < 3; s++)
      begin
         for (int n = 0; n < NUM_PKTS; n++)
         begin
            req.addr     = rand_bits(32);
            req.msg_type = 2'(rand_bits(2));
            r            = rand_bits(3);
            if (s == W)
               req.dst_id = 3'd3 + 3'(r % 5);
            else if (s == E)
               req.dst_id = {1'b0, r[1:0]};
            else if (n == 0)
               req.dst_id = 3'(MY_X >> 1);
            else
               req.dst_id = r[2:0];
            req.src_id = 3'(s);
            src_q[s].push_back(req);
            exp_q[route_ref(req.dst_id)][s].push_back(pack_ref(req));
         end
      end
      repeat (3) @(posedge clk_i);
      #1;
      reset_i    = 1'b0;
      freeze_chk = 1'b1;
      repeat (10) @(posedge clk_i);
      #1;
      freeze_chk = 1'b0;
      cfg_w_v_i  = 1'b1;
      cfg_addr_i = CFG_ADDR_FREEZE;
      cfg_data_i = '0;
      @(posedge clk_i);
      #1;
      cfg_w_v_i = 1'b0;
      run       = 1'b1;
      t = 0;
      while (!drained())
      begin
         @(posedge clk_i);
         t++;
         if (t > DRAIN_LIMIT)
         begin
            $display("Timeout: traffic did not drain within %0d cycles", DRAIN_LIMIT);
            abort_run();
         end
      end
      if (DUT.chk.fail_count == 0)
      begin
         $display("NO ERRORS");
         $finish;
      end
      else
      begin
         $display("Protocol checker reported %0d assertion failures", DUT.chk.fail_count);
         abort_run();
      end
   end

endmodule

/* tile_net_top.f */
rtl/tile_net_pkg.sv
rtl/tile_ctrl.sv
rtl/wh_inject.sv
rtl/wh_router.sv
rtl/wh_eject.sv
rtl/tile_net_top.sv
sim/tile_net_checker.sv
sim/tile_net_tb.sv
